// File: arcade_pkg.sv
package arcade_pkg;

	// widest word address any region may use
	localparam int MAX_AW = 15;

	typedef logic [7:0]  byte_t;
	typedef logic [15:0] word_t;
	typedef logic [23:0] dl_addr_t;
	typedef logic [7:0]  key_code_t;
	typedef logic [7:0]  joy_t;
	typedef logic [10:0] inp_t;     // active low
	typedef logic [MAX_AW-1:0] widx_t;

	typedef enum logic [1:0] {
		dl_idle,
		dl_active,
		dl_done
	} dl_state_t;

	// one staged memory write, one byte lane at a time
	typedef struct packed {
		logic  valid;
		logic  region;      // 0 program, 1 graphics
		logic  lane_hi;
		byte_t data;
		widx_t widx;
	} wr_req_t;

	localparam logic REGION_PRG = 1'b0;
	localparam logic REGION_GFX = 1'b1;

	// joystick bit positions
	localparam int JOY_RIGHT = 0;
	localparam int JOY_LEFT  = 1;
	localparam int JOY_DOWN  = 2;
	localparam int JOY_FIRE  = 4;

	// ps/2 set 2 scan codes
	localparam key_code_t KEY_DOWN  = 8'h72;
	localparam key_code_t KEY_LEFT  = 8'h6b;
	localparam key_code_t KEY_RIGHT = 8'h74;
	localparam key_code_t KEY_COIN  = 8'h76;   // esc
	localparam key_code_t KEY_FIRE  = 8'h29;   // space

endpackage

// File: rom_load_ctrl.sv
module rom_load_ctrl import arcade_pkg::*; #(
	parameter int ROM_AW = 12
) (
	input  logic     clk_sd,
	input  logic     rst_n,
	input  logic     dl_active,
	input  logic     dl_wr,
	input  dl_addr_t dl_addr,
	input  byte_t    dl_data,
	input  logic     status_reset,
	input  logic     button_reset,
	output wr_req_t  wr_req,
	output logic     loading,
	output logic     rom_loaded,
	output logic     core_reset
);

	dl_state_t state;
	dl_state_t state_nxt;

	logic  st_valid;
	logic  st_region;
	logic  st_lane_hi;
	byte_t st_data;
	widx_t st_widx;

	// the dl_active port hides the enum name, so the state value is scoped
	always_comb begin
		state_nxt = state;
		case (state)
			dl_idle: begin
				if (dl_active)
					state_nxt = arcade_pkg::dl_active;
			end
			arcade_pkg::dl_active: begin
				if (!dl_active)
					state_nxt = dl_done;
			end
			dl_done: begin
				if (dl_active)
					state_nxt = arcade_pkg::dl_active;   // new download
			end
			default: state_nxt = dl_idle;
		endcase
	end

	always_ff @(posedge clk_sd or negedge rst_n) begin
		if (!rst_n) begin
			state    <= dl_idle;
			st_valid <= 1'b0;
		end else begin
			state    <= state_nxt;
			st_valid <= dl_wr & dl_active;
		end
	end

	// staging register, decoded here and written one cycle later
	always_ff @(posedge clk_sd) begin
		if (dl_wr) begin
			st_region  <= dl_addr[ROM_AW+1];
			st_lane_hi <= dl_addr[0];
			st_data    <= dl_data;
			st_widx    <= widx_t'(dl_addr[ROM_AW:1]);
		end
	end

	assign wr_req = '{
		valid:   st_valid,
		region:  st_region,
		lane_hi: st_lane_hi,
		data:    st_data,
		widx:    st_widx
	};

	assign loading    = (state == arcade_pkg::dl_active);
	assign rom_loaded = (state == dl_done);

	always_ff @(posedge clk_sd or negedge rst_n) begin
		if (!rst_n)
			core_reset <= 1'b1;
		else
			core_reset <= status_reset | button_reset | ~rom_loaded;
	end

	// core stays held while the rom is not complete
	a_hold_core: assert property (@(posedge clk_sd) disable iff (!rst_n)
		!rom_loaded |=> core_reset)
		else $error("core_reset low after rom_loaded was low");

endmodule

// File: rom_store.sv
module rom_store import arcade_pkg::*; #(
	parameter int ROM_AW = 12
) (
	input  logic            clk_sd,
	input  logic            rst_n,
	input  wr_req_t         wr_req,
	input  logic            loading,
	input  logic [ROM_AW:0] prg_addr,   // byte address
	input  logic [ROM_AW-1:0] gfx_addr, // word address
	output byte_t           prg_data,
	output word_t           gfx_data
);

	localparam int DEPTH = 1 << ROM_AW;

	word_t prg_mem [DEPTH];
	word_t gfx_mem [DEPTH];

	logic [ROM_AW-1:0] waddr;
	logic [1:0]        lane_we;
	logic              prg_we;
	logic              gfx_we;

	word_t prg_word_q;
	logic  prg_hi_q;

	assign waddr   = wr_req.widx[ROM_AW-1:0];
	assign lane_we = wr_req.lane_hi ? 2'b10 : 2'b01;
	assign prg_we  = wr_req.valid && (wr_req.region == REGION_PRG);
	assign gfx_we  = wr_req.valid && (wr_req.region == REGION_GFX);

	// the same byte goes to whichever lane is enabled
	always_ff @(posedge clk_sd) begin
		if (prg_we && lane_we[0])
			prg_mem[waddr][7:0] <= wr_req.data;
		if (prg_we && lane_we[1])
			prg_mem[waddr][15:8] <= wr_req.data;
		if (gfx_we && lane_we[0])
			gfx_mem[waddr][7:0] <= wr_req.data;
		if (gfx_we && lane_we[1])
			gfx_mem[waddr][15:8] <= wr_req.data;
	end

	// registered reads give old data on a same cycle write
	always_ff @(posedge clk_sd) begin
		prg_word_q <= prg_mem[prg_addr[ROM_AW:1]];
		gfx_data   <= gfx_mem[gfx_addr];
	end

	always_ff @(posedge clk_sd or negedge rst_n) begin
		if (!rst_n)
			prg_hi_q <= 1'b0;
		else
			prg_hi_q <= prg_addr[0];
	end

	// cpu sees ff while the rom is being loaded
	always_comb begin
		if (loading)
			prg_data = 8'hff;
		else if (prg_hi_q)
			prg_data = prg_word_q[15:8];
		else
			prg_data = prg_word_q[7:0];
	end

	a_wr_in_load: assert property (@(posedge clk_sd) disable iff (!rst_n)
		wr_req.valid |-> loading)
		else $error("memory write outside of a download");

endmodule

// File: key_mapper.sv
module key_mapper import arcade_pkg::*; (
	input  logic      clk_sd,
	input  logic      rst_n,
	input  logic      key_strobe,
	input  logic      key_pressed,
	input  key_code_t key_code,
	input  joy_t      joy0,
	input  joy_t      joy1,
	input  logic      service,
	output inp_t      inp
);

	logic btn_down;
	logic btn_left;
	logic btn_right;
	logic btn_fire;
	logic btn_coin;

	logic p1_left, p1_right, p1_down, p1_fire;
	logic p2_left, p2_right, p2_down, p2_fire;

	always_ff @(posedge clk_sd or negedge rst_n) begin
		if (!rst_n) begin
			btn_down  <= 1'b0;
			btn_left  <= 1'b0;
			btn_right <= 1'b0;
			btn_fire  <= 1'b0;
			btn_coin  <= 1'b0;
		end else if (key_strobe) begin
			case (key_code)
				KEY_DOWN:  btn_down  <= key_pressed;
				KEY_LEFT:  btn_left  <= key_pressed;
				KEY_RIGHT: btn_right <= key_pressed;
				KEY_FIRE:  btn_fire  <= key_pressed;
				KEY_COIN:  btn_coin  <= key_pressed;
				default: ;   // unmapped key
			endcase
		end
	end

	// player 1 shares keyboard and joystick
	assign p1_left  = btn_left  | joy0[JOY_LEFT];
	assign p1_right = btn_right | joy0[JOY_RIGHT];
	assign p1_down  = btn_down  | joy0[JOY_DOWN];
	assign p1_fire  = btn_fire  | joy0[JOY_FIRE];

	assign p2_left  = joy1[JOY_LEFT];
	assign p2_right = joy1[JOY_RIGHT];
	assign p2_down  = joy1[JOY_DOWN];
	assign p2_fire  = joy1[JOY_FIRE];

	// bit 9 reads as one after the inversion
	assign inp = ~{service, 1'b0, btn_coin,
		p2_left, p2_right, p2_down, p2_fire,
		p1_left, p1_right, p1_down, p1_fire};

	a_key_known: assert property (@(posedge clk_sd) disable iff (!rst_n)
		key_strobe |-> !$isunknown(key_code))
		else $error("key_strobe with unknown key_code");

endmodule

// File: arcade_io_top.sv
module arcade_io_top import arcade_pkg::*; #(
	parameter int ROM_AW = 12
) (
	input  logic              clk_sd,
	input  logic              rst_n,
	input  logic              dl_active,
	input  logic              dl_wr,
	input  dl_addr_t          dl_addr,
	input  byte_t             dl_data,
	input  logic [ROM_AW:0]   prg_addr,
	input  logic [ROM_AW-1:0] gfx_addr,
	input  logic              status_reset,
	input  logic              button_reset,
	input  logic              key_strobe,
	input  logic              key_pressed,
	input  key_code_t         key_code,
	input  joy_t              joy0,
	input  joy_t              joy1,
	input  logic              service,
	output byte_t             prg_data,
	output word_t             gfx_data,
	output logic              core_reset,
	output logic              rom_loaded,
	output inp_t              inp
);

	wr_req_t wr_req;
	logic    loading;

	rom_load_ctrl #(
		.ROM_AW(ROM_AW)
	) u_load_ctrl (
		.clk_sd       (clk_sd),
		.rst_n        (rst_n),
		.dl_active    (dl_active),
		.dl_wr        (dl_wr),
		.dl_addr      (dl_addr),
		.dl_data      (dl_data),
		.status_reset (status_reset),
		.button_reset (button_reset),
		.wr_req       (wr_req),
		.loading      (loading),
		.rom_loaded   (rom_loaded),
		.core_reset   (core_reset)
	);

	rom_store #(
		.ROM_AW(ROM_AW)
	) u_rom_store (
		.clk_sd   (clk_sd),
		.rst_n    (rst_n),
		.wr_req   (wr_req),
		.loading  (loading),
		.prg_addr (prg_addr),
		.gfx_addr (gfx_addr),
		.prg_data (prg_data),
		.gfx_data (gfx_data)
	);

	key_mapper u_key_mapper (
		.clk_sd      (clk_sd),
		.rst_n       (rst_n),
		.key_strobe  (key_strobe),
		.key_pressed (key_pressed),
		.key_code    (key_code),
		.joy0        (joy0),
		.joy1        (joy1),
		.service     (service),
		.inp         (inp)
	);

endmodule

// File: tb_arcade_io.sv
module tb_arcade_io import arcade_pkg::*; ();

	localparam int AW         = 12;
	localparam int CLK_PERIOD = 8;
	localparam int N_PRG      = 48;
	localparam int N_GFX      = 24;
	localparam int N_JOY      = 12;
	localparam int N_RELOAD   = 8;
	// worst case cycles, every write may carry an idle cycle in front
	localparam int BUDGET = 4 + 2 * (N_PRG + 2 * N_GFX) + 14 + N_PRG + N_GFX + 4
		+ 8 + 28 + N_JOY + 2 + 2 * N_RELOAD + 14 + 4;

	logic      clk_sd = 1'b0;
	logic      rst_n;
	logic      dl_active;
	logic      dl_wr;
	dl_addr_t  dl_addr;
	byte_t     dl_data;
	logic [AW:0]   prg_addr;
	logic [AW-1:0] gfx_addr;
	logic      status_reset;
	logic      button_reset;
	logic      key_strobe;
	logic      key_pressed;
	key_code_t key_code;
	joy_t      joy0;
	joy_t      joy1;
	logic      service;
	byte_t     prg_data;
	word_t     gfx_data;
	logic      core_reset;
	logic      rom_loaded;
	inp_t      inp;

	// reference model
	byte_t prg_ref [2**(AW+1)];
	byte_t gfx_ref [2**(AW+1)];   // byte index, lane in bit 0
	logic [AW:0]   prg_list [$];
	logic [AW-1:0] gfx_list [$];
	logic [255:0]  key_held;
	logic [2:0]    act_hist;      // dl_active at the last three edges
	logic          model_loaded;
	logic          exp_core_q;
	inp_t          exp_inp;

	logic  chk_rst;
	logic  chk_prg;
	logic  chk_gfx;
	logic  chk_prg_q;
	logic  chk_gfx_q;
	byte_t exp_prg;
	byte_t exp_prg_q;
	word_t exp_gfx;
	word_t exp_gfx_q;

	logic [31:0] lfsr = 32'h2bfe06e2;
	int          err_count = 0;
	key_code_t   keys [5] = '{KEY_DOWN, KEY_LEFT, KEY_RIGHT, KEY_COIN, KEY_FIRE};

	arcade_io_top #(.ROM_AW(AW)) DUT (.*);

	initial begin
		forever #(CLK_PERIOD / 2) clk_sd = ~clk_sd;
	end

	always @(posedge clk_sd or negedge rst_n) begin
		if (!rst_n) begin
			act_hist     <= '0;
			model_loaded <= 1'b0;
			exp_core_q   <= 1'b1;
			key_held     <= '0;
			chk_prg_q    <= 1'b0;
			chk_gfx_q    <= 1'b0;
			exp_prg_q    <= '0;
			exp_gfx_q    <= '0;
		end else begin
			act_hist <= {act_hist[1:0], dl_active};
			if (dl_active)
				model_loaded <= 1'b0;
			else if (act_hist[0])
				model_loaded <= 1'b1;   // dl_active just fell
			exp_core_q <= status_reset | button_reset | ~model_loaded;
			if (key_strobe)
				key_held[key_code] <= key_pressed;
			chk_prg_q <= chk_prg;
			exp_prg_q <= exp_prg;
			chk_gfx_q <= chk_gfx;
			exp_gfx_q <= exp_gfx;
		end
	end

	// active low word, service on top
	assign exp_inp = ~{service, 1'b0, key_held[KEY_COIN],
		joy1[1], joy1[0], joy1[2], joy1[4],
		key_held[KEY_LEFT] | joy0[1], key_held[KEY_RIGHT] | joy0[0],
		key_held[KEY_DOWN] | joy0[2], key_held[KEY_FIRE] | joy0[4]};

	task automatic report_mismatch(input string name, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		err_count++;
		$display("FAIL %s expected %0h actual %0h at %0t", name, exp_v, act_v, $time);
	endtask

	task automatic report_error(input string msg);
		err_count++;
		$display("ERROR %s at %0t", msg, $time);
	endtask

	a_reset_state: assert property (@(posedge clk_sd) disable iff (!rst_n)
		chk_rst |-> {core_reset, rom_loaded, inp} == {1'b1, 1'b0, 11'h7ff})
		else report_mismatch("reset_state", 32'h17ff,
			32'({$sampled(core_reset), $sampled(rom_loaded), $sampled(inp)}));
	a_prg_ff: assert property (@(posedge clk_sd) disable iff (!rst_n)
		act_hist[0] |-> prg_data == 8'hff)
		else report_mismatch("prg_ff_during_load", 32'hff, 32'($sampled(prg_data)));
	a_prg_read: assert property (@(posedge clk_sd) disable iff (!rst_n)
		chk_prg_q |-> prg_data == exp_prg_q)
		else report_mismatch("prg_read", 32'($sampled(exp_prg_q)), 32'($sampled(prg_data)));
	a_gfx_read: assert property (@(posedge clk_sd) disable iff (!rst_n)
		chk_gfx_q |-> gfx_data == exp_gfx_q)
		else report_mismatch("gfx_read", 32'($sampled(exp_gfx_q)), 32'($sampled(gfx_data)));
	a_rom_loaded: assert property (@(posedge clk_sd) disable iff (!rst_n)
		rom_loaded == model_loaded)
		else report_mismatch("rom_loaded", 32'($sampled(model_loaded)),
			32'($sampled(rom_loaded)));
	a_core_reset: assert property (@(posedge clk_sd) disable iff (!rst_n)
		core_reset == exp_core_q)
		else report_mismatch("core_reset", 32'($sampled(exp_core_q)),
			32'($sampled(core_reset)));
	a_loaded_after_dl: assert property (@(posedge clk_sd) disable iff (!rst_n)
		act_hist == 3'b100 |-> rom_loaded && !core_reset)
		else report_mismatch("loaded_after_dl", 32'h2,
			32'({$sampled(rom_loaded), $sampled(core_reset)}));
	a_dl_clears_loaded: assert property (@(posedge clk_sd) disable iff (!rst_n)
		act_hist[0] |-> !rom_loaded)
		else report_mismatch("dl_clears_loaded", 32'h0, 32'($sampled(rom_loaded)));
	a_inp: assert property (@(posedge clk_sd) disable iff (!rst_n)
		inp == exp_inp)
		else report_mismatch("inp", 32'($sampled(exp_inp)), 32'($sampled(inp)));

	// galois form, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		repeat (n) begin
			v    = {v[30:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
	endtask

	// one download strobe, now and then after an idle cycle
	task automatic write_byte(input dl_addr_t a, input byte_t d);
		logic [31:0] v;
		rand_bits(1, v);
		if (v[0]) begin
			@(negedge clk_sd);
			dl_wr = 1'b0;
		end
		@(negedge clk_sd);
		dl_wr   = 1'b1;
		dl_addr = a;
		dl_data = d;
		rand_bits(AW + 1, v);
		prg_addr = v[AW:0];   // any address reads ff here
	endtask

	task automatic load_prg(input int n);
		logic [31:0] a;
		logic [31:0] d;
		repeat (n) begin
			rand_bits(AW + 1, a);
			rand_bits(8, d);
			write_byte(dl_addr_t'(a[AW:0]), d[7:0]);
			prg_ref[a[AW:0]] = d[7:0];
			prg_list.push_back(a[AW:0]);
		end
	endtask

	task automatic load_gfx(input int n);
		logic [31:0] w;
		logic [31:0] d;
		logic [AW:0] bidx;
		repeat (n) begin
			rand_bits(AW, w);
			rand_bits(16, d);
			gfx_list.push_back(w[AW-1:0]);
			bidx = {w[AW-1:0], 1'b0};
			write_byte(dl_addr_t'({1'b1, bidx}), d[7:0]);
			gfx_ref[bidx] = d[7:0];
			bidx = {w[AW-1:0], 1'b1};
			write_byte(dl_addr_t'({1'b1, bidx}), d[15:8]);
			gfx_ref[bidx] = d[15:8];
		end
	endtask

	task automatic end_download();
		@(negedge clk_sd);
		dl_wr = 1'b0;
		@(negedge clk_sd);
		dl_active = 1'b0;
	endtask

	task automatic wait_loaded();
		int n;
		n = 0;
		while (!rom_loaded && n < 8) begin
			@(negedge clk_sd);
			n++;
		end
		if (!rom_loaded)
			report_error("rom_loaded did not rise after the download ended");
		@(negedge clk_sd);
	endtask

	task automatic read_prg();
		foreach (prg_list[i]) begin
			@(negedge clk_sd);
			prg_addr = prg_list[i];
			exp_prg  = prg_ref[prg_list[i]];
			chk_prg  = 1'b1;
		end
		@(negedge clk_sd);
		chk_prg = 1'b0;
	endtask

	task automatic read_gfx();
		foreach (gfx_list[i]) begin
			@(negedge clk_sd);
			gfx_addr = gfx_list[i];
			exp_gfx  = {gfx_ref[{gfx_list[i], 1'b1}], gfx_ref[{gfx_list[i], 1'b0}]};
			chk_gfx  = 1'b1;
		end
		@(negedge clk_sd);
		chk_gfx = 1'b0;
	endtask

	task automatic pulse_reset(input logic use_button);
		@(negedge clk_sd);
		if (use_button)
			button_reset = 1'b1;
		else
			status_reset = 1'b1;
		@(negedge clk_sd);
		button_reset = 1'b0;
		status_reset = 1'b0;
		repeat (2) @(negedge clk_sd);
	endtask

	task automatic key_event(input key_code_t code, input logic pressed);
		@(negedge clk_sd);
		key_strobe  = 1'b1;
		key_code    = code;
		key_pressed = pressed;
		@(negedge clk_sd);
		key_strobe = 1'b0;
	endtask

	initial begin
		#(4 * BUDGET * CLK_PERIOD);
		$display("watchdog expired after %0d cycles, run did not finish", 4 * BUDGET);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		logic [31:0] r;
		rst_n        = 1'b0;
		dl_active    = 1'b0;
		dl_wr        = 1'b0;
		dl_addr      = '0;
		dl_data      = '0;
		prg_addr     = '0;
		gfx_addr     = '0;
		status_reset = 1'b0;
		button_reset = 1'b0;
		key_strobe   = 1'b0;
		key_pressed  = 1'b0;
		key_code     = '0;
		joy0         = '0;
		joy1         = '0;
		service      = 1'b0;
		chk_rst      = 1'b0;
		chk_prg      = 1'b0;
		chk_gfx      = 1'b0;
		exp_prg      = '0;
		exp_gfx      = '0;
		repeat (2) @(negedge clk_sd);
		rst_n   = 1'b1;
		chk_rst = 1'b1;
		@(negedge clk_sd);
		chk_rst   = 1'b0;
		dl_active = 1'b1;
		load_prg(N_PRG);
		load_gfx(N_GFX);
		end_download();
		wait_loaded();
		read_prg();
		read_gfx();
		pulse_reset(1'b0);
		pulse_reset(1'b1);
		foreach (keys[i]) begin
			key_event(keys[i], 1'b1);
			key_event(keys[i], 1'b0);
		end
		key_event(KEY_FIRE, 1'b1);
		key_event(8'h1c, 1'b1);   // not mapped
		key_event(8'h1c, 1'b0);
		key_event(KEY_FIRE, 1'b0);
		repeat (N_JOY) begin
			@(negedge clk_sd);
			rand_bits(8, r);
			joy0 = r[7:0];
			rand_bits(8, r);
			joy1 = r[7:0];
			rand_bits(1, r);
			service = r[0];
		end
		@(negedge clk_sd);
		joy0    = '0;
		joy1    = '0;
		service = 1'b0;
		// second download drops rom_loaded again
		dl_active = 1'b1;
		load_prg(N_RELOAD);
		end_download();
		wait_loaded();
		repeat (4) @(negedge clk_sd);
		$display("errors: %0d", err_count);
		if (err_count == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: flist.f
arcade_pkg.sv
rom_load_ctrl.sv
rom_store.sv
key_mapper.sv
arcade_io_top.sv
tb_arcade_io.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

log=sim.log

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_arcade_io -f flist.f -o tb_arcade_io
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

./obj_dir/tb_arcade_io > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q "TEST FAILED" "$log"; then
	exit 1
fi

if ! grep -q "TEST PASSED" "$log"; then
	echo "no result line found in $log"
	exit 1
fi

exit 0
